// File: verilog/rfq_pkg.sv
`default_nettype none

package rfq_pkg;

    // ------------------------------
    // Sizes and timing
    // ------------------------------

    // Number of queue entries, also the upstream credit count after reset
    localparam int QUEUE_DEPTH  = 16;
    // Credits downstream grants the queue after reset
    localparam int OUT_CREDITS  = 4;
    // Cycles the array takes to acknowledge a power enable change
    localparam int PG_ACK_DELAY = 4;

    // Register map
    localparam logic [0:0] REG_CTRL   = 1'b0;
    localparam logic [0:0] REG_STATUS = 1'b1;

    // ------------------------------
    // Types
    // ------------------------------

    typedef logic [29:0] entry_t;
    typedef logic [3:0]  rf_addr_t;
    // Occupancy must reach 16 so it needs one bit more than the address
    typedef logic [4:0]  occ_t;
    typedef logic [2:0]  out_credit_t;
    typedef logic [0:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // Power sequencing states, the code is visible in the status register
    typedef enum logic [2:0] {
        PG_AWAKE      = 3'd0,
        PG_ISOLATE    = 3'd1,
        PG_POWER_DOWN = 3'd2,
        PG_SLEEP      = 3'd3,
        PG_POWER_UP   = 3'd4,
        PG_DEISOLATE  = 3'd5
    } pg_state_e;

    // Word from upstream
    typedef struct packed {
        logic   valid;
        entry_t data;
    } q_in_t;

    // Word to downstream
    typedef struct packed {
        logic   valid;
        entry_t data;
    } q_out_t;

    // Software controls for the power controller
    typedef struct packed {
        logic sleep_req;
    } pg_cfg_t;

    // Power controls for the register file
    typedef struct packed {
        logic isol_en;
        logic pwr_enable_b;
    } pg_pwr_t;

endpackage

`default_nettype wire

// File: verilog/rf_pg_16x30.sv
`timescale 1ns/1ps
`default_nettype none

module rf_pg_16x30 (
     input  logic              clk
    ,input  logic              rst_n

    // Scan reset bypass
    ,input  logic              fscan_rstbypen
    ,input  logic              fscan_byprst_b

    // Write port
    ,input  logic              we
    ,input  rfq_pkg::rf_addr_t waddr
    ,input  rfq_pkg::entry_t   wdata

    // Read port
    ,input  logic              re
    ,input  rfq_pkg::rf_addr_t raddr
    ,output rfq_pkg::entry_t   rdata

    // Power interface
    ,input  rfq_pkg::pg_pwr_t  pwr
    ,output logic              pwr_enable_b_out
);

    logic [1:0] rst_sync;
    logic array_rst_n;
    logic [rfq_pkg::PG_ACK_DELAY-1:0] ack_sr;
    logic access_ok;
    rfq_pkg::entry_t mem [rfq_pkg::QUEUE_DEPTH];
    logic [rfq_pkg::QUEUE_DEPTH-1:0] entry_vld;
    rfq_pkg::entry_t rdata_q;

    // ------------------------------
    // Array reset
    // ------------------------------

    // Two flop synchronizer for the array reset
    // Release is delayed by two clocks after rst_n goes high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    // In scan mode the reset comes straight from the bypass pin
    assign array_rst_n = fscan_rstbypen ? fscan_byprst_b : rst_sync[1];

    // ------------------------------
    // Power acknowledge
    // ------------------------------

    // The power switch chain is modelled as a shift of the enable
    // The acknowledge follows each change of pwr_enable_b after PG_ACK_DELAY clocks
    always_ff @(posedge clk) begin
        if (!array_rst_n) begin
            ack_sr <= '0;
        end else begin
            ack_sr <= {ack_sr[rfq_pkg::PG_ACK_DELAY-2:0], pwr.pwr_enable_b};
        end
    end

    assign pwr_enable_b_out = ack_sr[rfq_pkg::PG_ACK_DELAY-1];

    // The array only responds when out of reset, not isolated and fully powered
    // A pending acknowledge means the rail has not settled yet
    assign access_ok = array_rst_n && !pwr.isol_en && !pwr.pwr_enable_b &&
                       !ack_sr[rfq_pkg::PG_ACK_DELAY-1];

    // ------------------------------
    // Storage
    // ------------------------------

    always_ff @(posedge clk) begin
        if (we && access_ok) begin
            mem[waddr] <= wdata;
        end
    end

    // Per entry valid bits stand for retained contents
    // Everything is lost once the rail is switched off
    always_ff @(posedge clk) begin
        if (!array_rst_n || pwr.pwr_enable_b) begin
            entry_vld <= '0;
        end else if (we && access_ok) begin
            entry_vld[waddr] <= 1'b1;
        end
    end

    // Registered read, data appears the clock after re is sampled
    // An entry that was never written since power-up reads as zero
    always_ff @(posedge clk) begin
        if (re && access_ok) begin
            rdata_q <= entry_vld[raddr] ? mem[raddr] : '0;
        end
    end

    assign rdata = rdata_q;

endmodule

`default_nettype wire

// File: verilog/pg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module pg_regs (
     input  logic               clk
    ,input  logic               rst_n

    // Software register port
    ,input  logic               reg_wr
    ,input  rfq_pkg::reg_addr_t reg_addr
    ,input  rfq_pkg::reg_data_t reg_wdata
    ,output rfq_pkg::reg_data_t reg_rdata

    // To the power controller
    ,output rfq_pkg::pg_cfg_t   cfg

    // Status sources
    ,input  rfq_pkg::pg_state_e state
    ,input  rfq_pkg::occ_t      occupancy
    ,input  logic               drop
);

    logic sleep_req_q;
    logic drop_err_q;
    rfq_pkg::reg_data_t status_word;

    // Sleep request lives in bit 0 of the control register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sleep_req_q <= 1'b0;
        end else if (reg_wr && (reg_addr == rfq_pkg::REG_CTRL)) begin
            sleep_req_q <= reg_wdata[0];
        end
    end

    // Sticky drop error
    // A new drop wins over a clear in the same cycle so no event gets lost
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drop_err_q <= 1'b0;
        end else if (drop) begin
            drop_err_q <= 1'b1;
        end else if (reg_wr && (reg_addr == rfq_pkg::REG_STATUS) && reg_wdata[8]) begin
            drop_err_q <= 1'b0;
        end
    end

    // Status layout is drop_err in bit 8, state in 7..5, occupancy in 4..0
    assign status_word = {7'b0, drop_err_q, state, occupancy};

    // Read data is combinational on the address
    always_comb begin
        case (reg_addr)
            rfq_pkg::REG_STATUS: reg_rdata = status_word;
            default:             reg_rdata = {15'b0, sleep_req_q};
        endcase
    end

    assign cfg.sleep_req = sleep_req_q;

endmodule

`default_nettype wire

// File: verilog/pg_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pg_ctrl (
     input  logic               clk
    ,input  logic               rst_n

    // Sleep request from software
    ,input  rfq_pkg::pg_cfg_t   cfg
    // Queue holds no data and nothing is on its way
    ,input  logic               empty

    // Power handshake with the register file
    ,input  logic               pwr_ack
    ,output rfq_pkg::pg_pwr_t   pwr

    // Status
    ,output rfq_pkg::pg_state_e state
    ,output logic               awake
);

    rfq_pkg::pg_state_e state_q;
    rfq_pkg::pg_state_e state_d;

    // ------------------------------
    // Sequencing FSM
    // ------------------------------

    // Power down goes isolate first, then switch off and wait for the ack
    // Power up is the mirror image with isolation removed last
    always_comb begin
        state_d = state_q;
        case (state_q)
            rfq_pkg::PG_AWAKE: begin
                // The array loses its contents, so only sleep when empty
                if (cfg.sleep_req && empty) begin
                    state_d = rfq_pkg::PG_ISOLATE;
                end
            end
            rfq_pkg::PG_ISOLATE: begin
                // Clamps are on for one cycle before the rail is switched
                state_d = rfq_pkg::PG_POWER_DOWN;
            end
            rfq_pkg::PG_POWER_DOWN: begin
                if (pwr_ack) begin
                    state_d = rfq_pkg::PG_SLEEP;
                end
            end
            rfq_pkg::PG_SLEEP: begin
                if (!cfg.sleep_req) begin
                    state_d = rfq_pkg::PG_POWER_UP;
                end
            end
            rfq_pkg::PG_POWER_UP: begin
                // Wait until the rail reports it is back on
                if (!pwr_ack) begin
                    state_d = rfq_pkg::PG_DEISOLATE;
                end
            end
            rfq_pkg::PG_DEISOLATE: begin
                state_d = rfq_pkg::PG_AWAKE;
            end
            default: begin
                state_d = rfq_pkg::PG_AWAKE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= rfq_pkg::PG_AWAKE;
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    // All outputs decode from the state flop so they change only on an edge
    // Isolation covers every state that is not fully awake
    assign pwr.isol_en = (state_q != rfq_pkg::PG_AWAKE);

    // The rail is off from POWER_DOWN until software asks to wake up
    assign pwr.pwr_enable_b = (state_q == rfq_pkg::PG_POWER_DOWN) ||
                              (state_q == rfq_pkg::PG_SLEEP);

    assign awake = (state_q == rfq_pkg::PG_AWAKE);
    assign state = state_q;

endmodule

`default_nettype wire

// File: verilog/credit_queue.sv
`timescale 1ns/1ps
`default_nettype none

module credit_queue (
     input  logic              clk
    ,input  logic              rst_n

    // Upstream credit interface
    ,input  rfq_pkg::q_in_t    in
    ,output logic              in_credit

    // Downstream credit interface
    ,output rfq_pkg::q_out_t   out
    ,input  logic              out_credit

    // Array may be accessed
    ,input  logic              awake

    // Register file ports
    ,output logic              we
    ,output rfq_pkg::rf_addr_t waddr
    ,output rfq_pkg::entry_t   wdata
    ,output logic              re
    ,output rfq_pkg::rf_addr_t raddr
    ,input  rfq_pkg::entry_t   rdata

    // Status
    ,output logic              empty
    ,output rfq_pkg::occ_t     occupancy
    ,output logic              drop
);

    rfq_pkg::rf_addr_t wr_ptr;
    rfq_pkg::rf_addr_t rd_ptr;
    rfq_pkg::occ_t occ_q;
    rfq_pkg::out_credit_t out_credit_cnt;
    logic out_valid_q;
    logic wr_go;
    logic rd_go;

    // ------------------------------
    // Write side
    // ------------------------------

    // Upstream spends a credit per word, so an accepted word always fits
    // While the array is not awake the word has nowhere to go and is dropped
    assign wr_go = in.valid && awake;
    assign drop  = in.valid && !awake;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (wr_go) begin
            wr_ptr <= wr_ptr + 4'd1;
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------

    // A read may only start if a credit is left after the word in flight
    // This keeps out.valid covered by a credit and allows back to back reads
    assign rd_go = awake && (occ_q != '0) && (out_credit_cnt > {2'b00, out_valid_q});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (rd_go) begin
            rd_ptr <= rd_ptr + 4'd1;
        end
    end

    // Occupancy counts words written but not yet read from the array
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occ_q <= '0;
        end else begin
            occ_q <= occ_q + rfq_pkg::occ_t'(wr_go) - rfq_pkg::occ_t'(rd_go);
        end
    end

    // Credit is spent when the word leaves and returned by out_credit
    // The count never goes past OUT_CREDITS since downstream only returns what it got
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_credit_cnt <= rfq_pkg::out_credit_t'(rfq_pkg::OUT_CREDITS);
        end else begin
            out_credit_cnt <= out_credit_cnt - rfq_pkg::out_credit_t'(out_valid_q)
                            + rfq_pkg::out_credit_t'(out_credit);
        end
    end

    // Valid follows the registered read data of the array by one stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= rd_go;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    assign we    = wr_go;
    assign waddr = wr_ptr;
    assign wdata = in.data;
    assign re    = rd_go;
    assign raddr = rd_ptr;

    assign out.valid = out_valid_q;
    assign out.data  = rdata;

    // The entry slot frees up when its word comes out of the array
    assign in_credit = out_valid_q;

    // Empty also excludes a word in flight and one arriving right now
    // so power down can never catch data on its way
    assign empty     = (occ_q == '0) && !out_valid_q && !in.valid;
    assign occupancy = occ_q;

endmodule

`default_nettype wire

// File: verilog/rfq_top.sv
`timescale 1ns/1ps
`default_nettype none

module rfq_top (
     input  logic               clk
    ,input  logic               rst_n

    // Scan reset bypass
    ,input  logic               fscan_rstbypen
    ,input  logic               fscan_byprst_b

    // Upstream
    ,input  rfq_pkg::q_in_t     in
    ,output logic               in_credit

    // Downstream
    ,output rfq_pkg::q_out_t    out
    ,input  logic               out_credit

    // Register port
    ,input  logic               reg_wr
    ,input  rfq_pkg::reg_addr_t reg_addr
    ,input  rfq_pkg::reg_data_t reg_wdata
    ,output rfq_pkg::reg_data_t reg_rdata
);

    // Array access
    logic              we;
    rfq_pkg::rf_addr_t waddr;
    rfq_pkg::entry_t   wdata;
    logic              re;
    rfq_pkg::rf_addr_t raddr;
    rfq_pkg::entry_t   rdata;

    // Power and status
    rfq_pkg::pg_pwr_t   pwr;
    logic               pwr_ack;
    rfq_pkg::pg_cfg_t   cfg;
    rfq_pkg::pg_state_e state;
    logic               awake;
    logic               empty;
    rfq_pkg::occ_t      occupancy;
    logic               drop;

    credit_queue i_credit_queue (
         .clk        (clk)
        ,.rst_n      (rst_n)
        ,.in         (in)
        ,.in_credit  (in_credit)
        ,.out        (out)
        ,.out_credit (out_credit)
        ,.awake      (awake)
        ,.we         (we)
        ,.waddr      (waddr)
        ,.wdata      (wdata)
        ,.re         (re)
        ,.raddr      (raddr)
        ,.rdata      (rdata)
        ,.empty      (empty)
        ,.occupancy  (occupancy)
        ,.drop       (drop)
    );

    // Both ports of the array run on the single clock
    rf_pg_16x30 i_rf (
         .clk              (clk)
        ,.rst_n            (rst_n)
        ,.fscan_rstbypen   (fscan_rstbypen)
        ,.fscan_byprst_b   (fscan_byprst_b)
        ,.we               (we)
        ,.waddr            (waddr)
        ,.wdata            (wdata)
        ,.re               (re)
        ,.raddr            (raddr)
        ,.rdata            (rdata)
        ,.pwr              (pwr)
        ,.pwr_enable_b_out (pwr_ack)
    );

    pg_ctrl i_pg_ctrl (
         .clk     (clk)
        ,.rst_n   (rst_n)
        ,.cfg     (cfg)
        ,.empty   (empty)
        ,.pwr_ack (pwr_ack)
        ,.pwr     (pwr)
        ,.state   (state)
        ,.awake   (awake)
    );

    pg_regs i_pg_regs (
         .clk       (clk)
        ,.rst_n     (rst_n)
        ,.reg_wr    (reg_wr)
        ,.reg_addr  (reg_addr)
        ,.reg_wdata (reg_wdata)
        ,.reg_rdata (reg_rdata)
        ,.cfg       (cfg)
        ,.state     (state)
        ,.occupancy (occupancy)
        ,.drop      (drop)
    );

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
     output logic clk
    ,output logic rst_n
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;

    // 20 ns clock period
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    // Reset is released 1 ns after an edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: test/rfq_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rfq_properties (
     input  logic                 clk
    ,input  logic                 rst_n
    ,input  logic                 out_valid
    ,input  rfq_pkg::out_credit_t credit_cnt
    ,input  logic                 isol_en
    ,input  logic                 pwr_enable_b
    ,input  logic                 pwr_ack
    ,input  logic                 we
    ,input  logic                 awake
    ,input  rfq_pkg::occ_t        occupancy
);

    // A word may only leave while the queue still holds a downstream credit
    a_valid_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (credit_cnt != '0))
        else $error("out.valid raised while the downstream credit count is zero");

    // The rail is never switched off without the clamps in place
    // Clamps also stay on until the acknowledge reports the rail is back
    a_off_means_isolated: assert property (@(posedge clk) disable iff (!rst_n)
        (pwr_enable_b || pwr_ack) |-> isol_en)
        else $error("rail off or not yet settled without isol_en");

    // No array write outside the awake state or while the rail still settles
    a_no_write_asleep: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> (awake && !pwr_ack))
        else $error("array write issued while the array is not awake");

    a_occupancy_bound: assert property (@(posedge clk) disable iff (!rst_n)
        occupancy <= rfq_pkg::occ_t'(rfq_pkg::QUEUE_DEPTH))
        else $error("occupancy above the queue depth");

endmodule

bind rfq_top rfq_properties i_rfq_properties (
     .clk          (clk)
    ,.rst_n        (rst_n)
    ,.out_valid    (out.valid)
    ,.credit_cnt   (i_credit_queue.out_credit_cnt)
    ,.isol_en      (pwr.isol_en)
    ,.pwr_enable_b (pwr.pwr_enable_b)
    ,.pwr_ack      (pwr_ack)
    ,.we           (we)
    ,.awake        (awake)
    ,.occupancy    (occupancy)
);

`default_nettype wire

// File: test/rfq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rfq_tb;

    // All six tests together take a few hundred cycles
    // The sleep and wake polls are the longest waits, so the limit leaves a wide margin
    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [31:0] LFSR_SEED      = 32'h151d_ed74;
    // A power sequence plus a drain takes well under this many status reads
    localparam int          POLL_LIMIT     = 40;

    logic               clk;
    logic               rst_n;
    rfq_pkg::q_in_t     in;
    logic               in_credit;
    rfq_pkg::q_out_t    out;
    logic               out_credit;
    logic               reg_wr;
    rfq_pkg::reg_addr_t reg_addr;
    rfq_pkg::reg_data_t reg_wdata;
    rfq_pkg::reg_data_t reg_rdata;

    // Reference model, each variable has a single writing process
    logic [31:0]     lfsr_state;
    rfq_pkg::entry_t ref_q[$];
    rfq_pkg::entry_t rx_q[$];
    logic            return_en;
    int              up_sent;
    int              rx_checked;
    int              in_credit_pulses;
    int              rx_total;
    int              credits_returned;
    int              proto_errors;
    int              error_count;
    int              check_total;
    int              cycle_count;

    tb_clock_gen i_clk_gen (
         .clk   (clk)
        ,.rst_n (rst_n)
    );

    rfq_top i_dut (
         .clk            (clk)
        ,.rst_n          (rst_n)
        ,.fscan_rstbypen (1'b0)
        ,.fscan_byprst_b (1'b1)
        ,.in             (in)
        ,.in_credit      (in_credit)
        ,.out            (out)
        ,.out_credit     (out_credit)
        ,.reg_wr         (reg_wr)
        ,.reg_addr       (reg_addr)
        ,.reg_wdata      (reg_wdata)
        ,.reg_rdata      (reg_rdata)
    );

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One step per data bit
    task automatic make_word(output rfq_pkg::entry_t w);
        for (int i = 0; i < 30; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w[i] = lfsr_state[0];
        end
    endtask

    // Sends n words back to back whenever upstream holds a credit
    // Words that the queue is expected to keep go into the reference queue
    task automatic send_words(input int n, input logic store);
        rfq_pkg::entry_t w;
        int sent;
        sent = 0;
        while (sent < n) begin
            @(posedge clk);
            #1;
            if (rfq_pkg::QUEUE_DEPTH - up_sent + in_credit_pulses > 0) begin
                make_word(w);
                in.valid = 1'b1;
                in.data = w;
                up_sent++;
                sent++;
                if (store) begin
                    ref_q.push_back(w);
                end
            end else begin
                in.valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        in.valid = 1'b0;
    endtask

    task automatic write_reg(input rfq_pkg::reg_addr_t a, input rfq_pkg::reg_data_t d);
        @(posedge clk);
        #1;
        reg_wr = 1'b1;
        reg_addr = a;
        reg_wdata = d;
        @(posedge clk);
        #1;
        reg_wr = 1'b0;
    endtask

    // Read data is combinational, so it is taken at the falling edge
    task automatic read_reg(input rfq_pkg::reg_addr_t a, output rfq_pkg::reg_data_t d);
        @(posedge clk);
        #1;
        reg_addr = a;
        @(negedge clk);
        d = reg_rdata;
    endtask

    task automatic wait_rx(input int n);
        while (rx_total - rx_checked < n) begin
            @(negedge clk);
        end
    endtask

    // Lets every owed downstream credit reach the queue
    task automatic settle_credits();
        while (rx_total != credits_returned) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // Polls the status register until the target state shows up or the limit runs out
    task automatic poll_state(input rfq_pkg::pg_state_e target);
        rfq_pkg::reg_data_t d;
        int polls;
        polls = 1;
        read_reg(rfq_pkg::REG_STATUS, d);
        while ((rfq_pkg::pg_state_e'(d[7:5]) != target) && (polls < POLL_LIMIT)) begin
            read_reg(rfq_pkg::REG_STATUS, d);
            polls++;
        end
        check_state(rfq_pkg::pg_state_e'(d[7:5]), target, "state reached by polling");
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic check_entry(input rfq_pkg::entry_t got, input rfq_pkg::entry_t exp,
                               input string what);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at time %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_state(input rfq_pkg::pg_state_e got, input rfq_pkg::pg_state_e exp,
                               input string what);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at time %0t: %s, got %s expected %s",
                     $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_occupancy(input rfq_pkg::occ_t got, input rfq_pkg::occ_t exp,
                                   input string what);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("Mismatch at time %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        check_total++;
        if (got != exp) begin
            error_count++;
            $display("Mismatch at time %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // Every received word since the last call is matched against the reference in order
    task automatic compare_rx(input string what);
        rfq_pkg::entry_t exp;
        while (rx_checked < rx_q.size()) begin
            if (ref_q.size() == 0) begin
                error_count++;
                $display("Error at time %0t: %s, the queue delivered a word never sent",
                         $time, what);
            end else begin
                exp = ref_q.pop_front();
                check_entry(rx_q[rx_checked], exp, what);
            end
            rx_checked++;
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic test_reset_state();
        rfq_pkg::reg_data_t d;
        // Covers the two-cycle release of the array reset
        repeat (6) @(posedge clk);
        check_count(rx_total, 0, "out.valid pulses after reset");
        check_count(in_credit_pulses, 0, "in_credit pulses after reset");
        read_reg(rfq_pkg::REG_STATUS, d);
        check_state(rfq_pkg::pg_state_e'(d[7:5]), rfq_pkg::PG_AWAKE, "state after reset");
        check_occupancy(d[4:0], '0, "occupancy after reset");
        check_count(int'(d[8]), 0, "drop_err after reset");
        read_reg(rfq_pkg::REG_CTRL, d);
        check_count(int'(d[0]), 0, "sleep_req after reset");
    endtask

    task automatic test_in_order();
        int pulses_base;
        pulses_base = in_credit_pulses;
        return_en = 1'b1;
        send_words(rfq_pkg::QUEUE_DEPTH, 1'b1);
        wait_rx(rfq_pkg::QUEUE_DEPTH);
        compare_rx("in-order word");
        // in_credit comes with each out.valid, so both counts are final here
        check_count(in_credit_pulses - pulses_base, rfq_pkg::QUEUE_DEPTH, "in_credit pulses");
        settle_credits();
    endtask

    task automatic test_back_pressure();
        rfq_pkg::reg_data_t d;
        return_en = 1'b0;
        send_words(10, 1'b1);
        wait_rx(rfq_pkg::OUT_CREDITS);
        // Nothing more may come out while no credit is returned
        repeat (20) @(posedge clk);
        check_count(rx_total - rx_checked, rfq_pkg::OUT_CREDITS, "words sent without credits");
        read_reg(rfq_pkg::REG_STATUS, d);
        check_occupancy(d[4:0], rfq_pkg::occ_t'(10 - rfq_pkg::OUT_CREDITS),
                        "occupancy under back-pressure");
        return_en = 1'b1;
        wait_rx(10);
        compare_rx("back-pressure word");
        settle_credits();
    endtask

    task automatic test_sleep_when_empty();
        rfq_pkg::reg_data_t d;
        return_en = 1'b0;
        send_words(6, 1'b1);
        wait_rx(rfq_pkg::OUT_CREDITS);
        write_reg(rfq_pkg::REG_CTRL, 16'h0001);
        repeat (10) @(posedge clk);
        read_reg(rfq_pkg::REG_STATUS, d);
        check_state(rfq_pkg::pg_state_e'(d[7:5]), rfq_pkg::PG_AWAKE, "state with words queued");
        check_occupancy(d[4:0], rfq_pkg::occ_t'(6 - rfq_pkg::OUT_CREDITS),
                        "occupancy before drain");
        read_reg(rfq_pkg::REG_CTRL, d);
        check_count(int'(d[0]), 1, "sleep_req readback");
        // Returning credits drains the queue and lets the power down start
        return_en = 1'b1;
        wait_rx(6);
        poll_state(rfq_pkg::PG_SLEEP);
        compare_rx("word drained before sleep");
        settle_credits();
    endtask

    task automatic test_drop_asleep();
        rfq_pkg::reg_data_t d;
        int rx_base;
        rx_base = rx_total;
        // The dropped word never frees a slot, so its upstream credit stays spent
        send_words(1, 1'b0);
        repeat (20) @(posedge clk);
        check_count(rx_total - rx_base, 0, "words delivered while asleep");
        read_reg(rfq_pkg::REG_STATUS, d);
        check_state(rfq_pkg::pg_state_e'(d[7:5]), rfq_pkg::PG_SLEEP, "state after drop");
        check_count(int'(d[8]), 1, "drop_err after drop");
    endtask

    task automatic test_wake_recover();
        rfq_pkg::reg_data_t d;
        write_reg(rfq_pkg::REG_CTRL, 16'h0000);
        poll_state(rfq_pkg::PG_AWAKE);
        write_reg(rfq_pkg::REG_STATUS, 16'h0100);
        read_reg(rfq_pkg::REG_STATUS, d);
        check_count(int'(d[8]), 0, "drop_err after clear");
        return_en = 1'b1;
        send_words(8, 1'b1);
        wait_rx(8);
        compare_rx("word after wake");
        settle_credits();
        read_reg(rfq_pkg::REG_STATUS, d);
        check_occupancy(d[4:0], '0, "occupancy at the end");
    endtask

    // ------------------------------
    // Downstream model and monitor
    // ------------------------------

    // Credits go back one per cycle after edge plus 1 ns, outputs are taken at the falling edge
    initial begin
        out_credit = 1'b0;
        rx_total = 0;
        credits_returned = 0;
        in_credit_pulses = 0;
        proto_errors = 0;
        forever begin
            @(posedge clk);
            #1;
            if (return_en && (rx_total > credits_returned)) begin
                out_credit = 1'b1;
                credits_returned++;
            end else begin
                out_credit = 1'b0;
            end
            @(negedge clk);
            if (rst_n) begin
                if (out.valid) begin
                    if (rx_total - credits_returned >= rfq_pkg::OUT_CREDITS) begin
                        proto_errors++;
                        $display("Error at time %0t: out.valid with no downstream credit left",
                                 $time);
                    end
                    rx_q.push_back(out.data);
                    rx_total++;
                end
                if (in_credit) begin
                    in_credit_pulses++;
                end
            end
        end
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Timeout: the run stopped after %0d cycles, a wait never ended",
                         cycle_count);
                $display("sim failed");
                $finish;
            end
        end
    end

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        in = '0;
        reg_wr = 1'b0;
        reg_addr = rfq_pkg::REG_CTRL;
        reg_wdata = '0;
        return_en = 1'b0;
        lfsr_state = LFSR_SEED;
        up_sent = 0;
        rx_checked = 0;
        error_count = 0;
        check_total = 0;

        @(posedge rst_n);
        test_reset_state();
        test_in_order();
        test_back_pressure();
        test_sleep_when_empty();
        test_drop_asleep();
        test_wake_recover();

        $display("Done: %0d checks, %0d mismatches, %0d protocol errors",
                 check_total, error_count, proto_errors);
        if ((error_count == 0) && (proto_errors == 0)) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
verilog/rfq_pkg.sv
verilog/rf_pg_16x30.sv
verilog/pg_regs.sv
verilog/pg_ctrl.sv
verilog/credit_queue.sv
verilog/rfq_top.sv
test/tb_clock_gen.sv
test/rfq_properties.sv
test/rfq_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the queue testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=rfq_sim

verilator --binary --timing --assert --top-module rfq_tb -Mdir obj_dir -o "$BIN" -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    echo "Result: PASS"
    exit 0
fi

echo "Result: FAIL"
exit 1
